/* src/gemm_pkg.sv */
package gemm_pkg;

    // ==================
    // Widths
    // ==================
    localparam int CMD_W          = 32;  // Host command word
    localparam int ELEM_W         = 8;   // One signed element
    localparam int ELEMS_PER_WORD = 4;   // Elements packed per data word
    localparam int ACC_W          = 24;  // Dot product accumulator
    localparam int RES_W          = 16;  // Saturated result
    localparam int TILE_AW        = 8;   // Tile memory address

    // Opcodes, top nibble of a header word
    localparam logic [3:0] OP_NOP  = 4'd0;
    localparam logic [3:0] OP_LOAD = 4'd1;
    localparam logic [3:0] OP_TILE = 4'd2;

    typedef logic signed [ELEM_W-1:0] elem_t;

    // LOAD header, count data words follow it
    typedef struct packed {
        logic [3:0]         opcode;
        logic               side;    // 0 left, 1 right
        logic [2:0]         spare;
        logic [7:0]         count;   // 1 to 255 words
        logic [TILE_AW-1:0] addr;    // First tile address
        logic [7:0]         pad;
    } load_hdr_t;

    // TILE header
    typedef struct packed {
        logic [3:0]  opcode;
        logic [3:0]  dim_b;   // Left rows
        logic [3:0]  dim_c;   // Right columns
        logic [3:0]  dim_v;   // Words per vector
        logic [3:0]  shift;   // Arithmetic right shift of each sum
        logic [11:0] spare;
    } tile_hdr_t;

    // One FIFO word, header or data depending on the decoder state
    typedef union packed {
        load_hdr_t                  load_hdr;
        tile_hdr_t                  tile_hdr;
        elem_t [ELEMS_PER_WORD-1:0] data;      // Element 0 in the low byte
    } cmd_word_t;

    typedef struct packed {
        logic [3:0] dim_b;
        logic [3:0] dim_c;
        logic [3:0] dim_v;
        logic [3:0] shift;
    } tile_job_t;

    typedef struct packed {
        logic               en;
        logic               side;
        logic [TILE_AW-1:0] addr;
        logic [CMD_W-1:0]   data;
    } tile_wr_t;

    typedef logic signed [RES_W-1:0] res_word_t;

endpackage : gemm_pkg

/* src/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 16
) (
    input  logic             i_clk,
    input  logic             i_rst_n,
    // Write side
    input  logic [WIDTH-1:0] i_data,
    input  logic             i_valid,
    output logic             o_ready,
    // Read side
    output logic [WIDTH-1:0] o_data,
    output logic             o_valid,
    input  logic             i_ready
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [AW:0]   FULL_CNT = (AW+1)'(DEPTH);
    localparam logic [AW-1:0] LAST_PTR = AW'(DEPTH - 1);  // Pointer wrap point

    logic [WIDTH-1:0] mem [DEPTH];  // Storage, no reset
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;        // Words held
    logic             push;
    logic             pop;

    assign o_ready = (count != FULL_CNT);  // Low only when full
    assign o_valid = (count != '0);
    assign o_data  = mem[rd_ptr];         // Head word straight from the register file
    assign push    = i_valid && o_ready;
    assign pop     = o_valid && i_ready;

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    // ==================
    // Pointers and count
    // ==================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                       // Idle or both, count holds
            endcase
        end
    end

endmodule : sync_fifo

/* src/master_control.sv */
`timescale 1ns/1ps

module master_control
    import gemm_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    // Command FIFO side
    input  cmd_word_t i_cmd,
    input  logic      i_cmd_valid,
    output logic      o_cmd_ready,
    // Tile memory writes
    output tile_wr_t  o_tile_wr,
    // Compute engine job
    output tile_job_t o_job,
    output logic      o_job_valid,
    input  logic      i_job_ready,
    input  logic      i_job_done,
    output logic      o_busy
);

    typedef enum logic [1:0] {
        ST_IDLE,       // Decode one header per cycle
        ST_LOAD_DATA,  // Same FIFO word read as data
        ST_TILE_WAIT   // Job handed off, wait for done
    } mc_state_t;

    mc_state_t          state;
    logic [TILE_AW-1:0] wr_addr;     // Next tile address
    logic [7:0]         words_left;  // Data words still owed by the LOAD
    logic               wr_side;     // Latched side bit
    logic               cmd_take;
    logic               tile_hdr;    // TILE header taken this cycle

    assign o_cmd_ready = (state != ST_TILE_WAIT);  // Stall the FIFO during a TILE
    assign cmd_take    = i_cmd_valid && o_cmd_ready;
    assign o_busy      = (state != ST_IDLE);
    assign tile_hdr    = (state == ST_IDLE) && i_cmd_valid &&
                         (i_cmd.tile_hdr.opcode == OP_TILE);

    // Write port, one word per FIFO beat
    always_comb begin
        o_tile_wr.en   = cmd_take && (state == ST_LOAD_DATA);
        o_tile_wr.side = wr_side;
        o_tile_wr.addr = wr_addr;
        o_tile_wr.data = i_cmd.data;
    end

    // ==================
    // Decode FSM
    // ==================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= ST_IDLE;
            wr_addr     <= '0;
            words_left  <= '0;
            wr_side     <= 1'b0;
            o_job_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_cmd_valid) begin
                        // Opcode sits in the same nibble in both header views
                        case (i_cmd.load_hdr.opcode)
                            OP_LOAD: begin
                                wr_side    <= i_cmd.load_hdr.side;
                                wr_addr    <= i_cmd.load_hdr.addr;
                                words_left <= i_cmd.load_hdr.count;
                                if (i_cmd.load_hdr.count != '0) begin
                                    state <= ST_LOAD_DATA;  // Empty LOAD is dropped
                                end
                            end
                            OP_TILE: begin
                                o_job_valid <= 1'b1;
                                state       <= ST_TILE_WAIT;
                            end
                            OP_NOP:  ;  // Consumed, nothing to do
                            default: ;  // Unknown opcode swallowed
                        endcase
                    end
                end
                ST_LOAD_DATA: begin
                    if (cmd_take) begin
                        wr_addr    <= wr_addr + 1'b1;
                        words_left <= words_left - 1'b1;
                        if (words_left == 8'd1) begin
                            state <= ST_IDLE;  // Last data word
                        end
                    end
                end
                ST_TILE_WAIT: begin
                    if (o_job_valid && i_job_ready) begin
                        o_job_valid <= 1'b0;   // Engine took the job
                    end
                    if (i_job_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Job payload from the TILE header
    always_ff @(posedge i_clk) begin
        if (tile_hdr) begin
            o_job.dim_b <= i_cmd.tile_hdr.dim_b;
            o_job.dim_c <= i_cmd.tile_hdr.dim_c;
            o_job.dim_v <= i_cmd.tile_hdr.dim_v;
            o_job.shift <= i_cmd.tile_hdr.shift;
        end
    end

endmodule : master_control

/* src/tile_buffer.sv */
`timescale 1ns/1ps

module tile_buffer
    import gemm_pkg::*;
#(
    parameter int DEPTH = 256
) (
    input  logic               i_clk,
    // Write port from master control
    input  tile_wr_t           i_tile_wr,
    // Dual read from compute engine
    input  logic [TILE_AW-1:0] i_left_addr,
    input  logic [TILE_AW-1:0] i_right_addr,
    output logic [CMD_W-1:0]   o_left_data,
    output logic [CMD_W-1:0]   o_right_data
);

    // Index 0 is the left tile, 1 the right
    logic [CMD_W-1:0] mem [2][DEPTH];

    // Write lands at the edge, side bit selects the tile
    always_ff @(posedge i_clk) begin
        if (i_tile_wr.en) begin
            mem[i_tile_wr.side][i_tile_wr.addr] <= i_tile_wr.data;
        end
    end

    // ==================
    // Synchronous reads
    // ==================
    always_ff @(posedge i_clk) begin
        o_left_data  <= mem[0][i_left_addr];   // Data one cycle after address
        o_right_data <= mem[1][i_right_addr];
    end

endmodule : tile_buffer

/* src/compute_engine.sv */
`timescale 1ns/1ps

module compute_engine
    import gemm_pkg::*;
(
    input  logic               i_clk,
    input  logic               i_rst_n,
    // Job side
    input  tile_job_t          i_job,
    input  logic               i_job_valid,
    output logic               o_job_ready,
    output logic               o_job_done,
    // Tile reads
    output logic [TILE_AW-1:0] o_left_addr,
    output logic [TILE_AW-1:0] o_right_addr,
    input  logic [CMD_W-1:0]   i_left_data,
    input  logic [CMD_W-1:0]   i_right_data,
    // Results
    output res_word_t          o_res,
    output logic               o_res_valid,
    input  logic               i_res_ready,
    output logic               o_busy
);

    localparam logic signed [ACC_W-1:0] RES_MAX = ACC_W'((2 ** (RES_W - 1)) - 1);
    localparam logic signed [ACC_W-1:0] RES_MIN = ACC_W'(-(2 ** (RES_W - 1)));

    typedef enum logic {
        CE_IDLE,
        CE_RUN
    } ce_state_t;

    ce_state_t                  state;
    tile_job_t                  job;          // Latched dimensions
    logic [3:0]                 b_cnt;        // Left row
    logic [3:0]                 c_cnt;        // Right column
    logic [3:0]                 w_cnt;        // Word within the vector
    logic [TILE_AW-1:0]         left_base;    // b * V
    logic [TILE_AW-1:0]         right_base;   // c * V
    logic                       issued_all;   // Every read issued
    logic                       w_last;
    logic                       stall;
    logic                       rd_en;
    logic                       finish;
    logic                       m_valid;      // MAC stage holds a word
    logic                       m_first;
    logic                       m_last;
    elem_t [ELEMS_PER_WORD-1:0] lw;
    elem_t [ELEMS_PER_WORD-1:0] rw;
    logic signed [2*ELEM_W-1:0] prod [ELEMS_PER_WORD];
    logic signed [ACC_W-1:0]    acc;
    logic signed [ACC_W-1:0]    dot;
    logic signed [ACC_W-1:0]    sum;
    logic signed [ACC_W-1:0]    shifted;
    res_word_t                  sat;

    assign o_job_ready = (state == CE_IDLE);
    assign o_busy      = (state != CE_IDLE);

    // ==================
    // Read stage
    // ==================
    assign w_last       = (w_cnt == job.dim_v - 4'd1);
    assign o_left_addr  = left_base + TILE_AW'(w_cnt);
    assign o_right_addr = right_base + TILE_AW'(w_cnt);

    // A last word may only issue if the output register is sure to be free when it lands
    assign stall  = w_last && ((o_res_valid && !i_res_ready) || (m_valid && m_last));
    assign rd_en  = (state == CE_RUN) && !issued_all && !stall;
    assign finish = (state == CE_RUN) && issued_all && !m_valid &&
                    o_res_valid && i_res_ready;  // Final result accepted

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state       <= CE_IDLE;
            b_cnt       <= '0;
            c_cnt       <= '0;
            w_cnt       <= '0;
            left_base   <= '0;
            right_base  <= '0;
            issued_all  <= 1'b0;
            m_valid     <= 1'b0;
            m_first     <= 1'b0;
            m_last      <= 1'b0;
            o_res_valid <= 1'b0;
            o_job_done  <= 1'b0;
        end else begin
            o_job_done <= finish;       // One cycle pulse
            m_valid    <= rd_en;        // MAC runs one cycle behind the read
            m_first    <= (w_cnt == '0);
            m_last     <= w_last;

            if (state == CE_IDLE) begin
                if (i_job_valid) begin
                    state      <= CE_RUN;
                    b_cnt      <= '0;
                    c_cnt      <= '0;
                    w_cnt      <= '0;
                    left_base  <= '0;
                    right_base <= '0;
                    issued_all <= 1'b0;
                end
            end else if (finish) begin
                state <= CE_IDLE;
            end

            if (rd_en) begin
                if (!w_last) begin
                    w_cnt <= w_cnt + 1'b1;
                end else begin
                    w_cnt <= '0;
                    if (c_cnt != job.dim_c - 4'd1) begin
                        c_cnt      <= c_cnt + 1'b1;
                        right_base <= right_base + TILE_AW'(job.dim_v);
                    end else begin
                        c_cnt      <= '0;
                        right_base <= '0;              // Back to first column
                        if (b_cnt == job.dim_b - 4'd1) begin
                            issued_all <= 1'b1;
                        end else begin
                            b_cnt     <= b_cnt + 1'b1;
                            left_base <= left_base + TILE_AW'(job.dim_v);
                        end
                    end
                end
            end

            // Output register handshake
            if (m_valid && m_last) begin
                o_res_valid <= 1'b1;
            end else if (i_res_ready) begin
                o_res_valid <= 1'b0;
            end
        end
    end

    // ==================
    // MAC stage
    // ==================
    assign lw = i_left_data;
    assign rw = i_right_data;

    always_comb begin
        dot = '0;
        for (int e = 0; e < ELEMS_PER_WORD; e++) begin
            prod[e] = lw[e] * rw[e];  // Signed 8x8
            dot     = dot + prod[e];
        end
        sum     = m_first ? dot : acc + dot;  // Restart on a new vector
        shifted = sum >>> job.shift;
        if (shifted > RES_MAX) begin
            sat = RES_W'(RES_MAX);
        end else if (shifted < RES_MIN) begin
            sat = RES_W'(RES_MIN);
        end else begin
            sat = RES_W'(shifted);
        end
    end

    // Job, accumulator and result payload
    always_ff @(posedge i_clk) begin
        if ((state == CE_IDLE) && i_job_valid) begin
            job <= i_job;
        end
        if (m_valid) begin
            acc <= sum;
        end
        if (m_valid && m_last) begin
            o_res <= sat;
        end
    end

endmodule : compute_engine

/* src/engine_top.sv */
`timescale 1ns/1ps

module engine_top
    import gemm_pkg::*;
#(
    parameter int TILE_DEPTH = 2 ** TILE_AW,  // Words per tile memory
    parameter int CMD_DEPTH  = 16,
    parameter int RES_DEPTH  = 16
) (
    input  logic      i_clk,
    input  logic      i_rst_n,
    // Host command side
    input  cmd_word_t i_cmd,
    input  logic      i_cmd_valid,
    output logic      o_cmd_ready,
    // Host result side
    output res_word_t o_res,
    output logic      o_res_valid,
    input  logic      i_res_ready,
    output logic      o_busy
);

    // ==================
    // Internal wiring
    // ==================
    cmd_word_t          fifo_cmd;        // Command FIFO -> control
    logic               fifo_cmd_valid;
    logic               fifo_cmd_ready;
    tile_wr_t           tile_wr;         // Control -> tile memories
    tile_job_t          job;             // Control -> engine
    logic               job_valid;
    logic               job_ready;
    logic               job_done;
    logic [TILE_AW-1:0] left_addr;
    logic [TILE_AW-1:0] right_addr;
    logic [CMD_W-1:0]   left_data;
    logic [CMD_W-1:0]   right_data;
    res_word_t          res;             // Engine -> result FIFO
    logic               res_valid;
    logic               res_ready;
    logic               mc_busy;
    logic               ce_busy;

    sync_fifo #(.WIDTH(CMD_W), .DEPTH(CMD_DEPTH)) u_cmd_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (i_cmd),
        .i_valid (i_cmd_valid),
        .o_ready (o_cmd_ready),
        .o_data  (fifo_cmd),
        .o_valid (fifo_cmd_valid),
        .i_ready (fifo_cmd_ready)
    );

    master_control u_master_control (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd       (fifo_cmd),
        .i_cmd_valid (fifo_cmd_valid),
        .o_cmd_ready (fifo_cmd_ready),
        .o_tile_wr   (tile_wr),
        .o_job       (job),
        .o_job_valid (job_valid),
        .i_job_ready (job_ready),
        .i_job_done  (job_done),
        .o_busy      (mc_busy)
    );

    tile_buffer #(.DEPTH(TILE_DEPTH)) u_tile_buffer (
        .i_clk        (i_clk),
        .i_tile_wr    (tile_wr),
        .i_left_addr  (left_addr),
        .i_right_addr (right_addr),
        .o_left_data  (left_data),
        .o_right_data (right_data)
    );

    compute_engine u_compute_engine (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_job        (job),
        .i_job_valid  (job_valid),
        .o_job_ready  (job_ready),
        .o_job_done   (job_done),
        .o_left_addr  (left_addr),
        .o_right_addr (right_addr),
        .i_left_data  (left_data),
        .i_right_data (right_data),
        .o_res        (res),
        .o_res_valid  (res_valid),
        .i_res_ready  (res_ready),
        .o_busy       (ce_busy)
    );

    sync_fifo #(.WIDTH(RES_W), .DEPTH(RES_DEPTH)) u_res_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_data  (res),
        .i_valid (res_valid),
        .o_ready (res_ready),
        .o_data  (o_res),
        .o_valid (o_res_valid),
        .i_ready (i_res_ready)
    );

    // Busy while anything is queued, running or waiting for the host
    assign o_busy = mc_busy || ce_busy || fifo_cmd_valid || o_res_valid;

endmodule : engine_top

/* testbench/engine_sva.sv */
`timescale 1ns/1ps

module engine_sva
    import gemm_pkg::*;
(
    input logic      i_clk,
    input logic      i_rst_n,
    input logic      i_cmd_ready,       // Top level o_cmd_ready
    input logic      i_fifo_cmd_valid,  // Command FIFO not empty
    input res_word_t i_res,
    input logic      i_res_valid,
    input logic      i_res_ready
);

    // ==================
    // Result handshake
    // ==================
    property res_hold_p;
        @(posedge i_clk) disable iff (!i_rst_n)
            (i_res_valid && !i_res_ready) |=> (i_res_valid && $stable(i_res));
    endproperty
    a_res_hold : assert property (res_hold_p)
        else $error("o_res or o_res_valid changed while the host stalled");

    a_res_reset : assert property (@(posedge i_clk) !i_rst_n |-> !i_res_valid)
        else $error("o_res_valid high during reset");

    // Empty command FIFO accepts right after reset
    property cmd_ready_p;
        @(posedge i_clk) ($rose(i_rst_n) && !i_fifo_cmd_valid) |=> i_cmd_ready;
    endproperty
    a_cmd_ready : assert property (cmd_ready_p)
        else $error("o_cmd_ready low one cycle after reset");

endmodule : engine_sva

bind engine_top engine_sva u_engine_sva (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_cmd_ready      (o_cmd_ready),
    .i_fifo_cmd_valid (fifo_cmd_valid),
    .i_res            (o_res),
    .i_res_valid      (o_res_valid),
    .i_res_ready      (i_res_ready)
);

/* testbench/tb_engine_top.sv */
`timescale 1ns/1ps

module tb_engine_top
    import gemm_pkg::*;
();

    localparam int NSTEPS = 21;
    localparam int TDEPTH = 2 ** TILE_AW;

    typedef enum logic [2:0] {
        K_LOAD,  // Header plus count data words
        K_TILE,
        K_NOP,
        K_BAD,   // Unknown opcode
        K_RAND   // Result ready from LFSR from here on
    } kind_t;

    typedef struct packed {
        kind_t      kind;
        logic       side;
        logic [7:0] addr;
        logic [7:0] count;
        logic [3:0] dim_b;
        logic [3:0] dim_c;
        logic [3:0] dim_v;
        logic [3:0] shift;
        logic       rnd;    // LFSR data, else fill byte
        logic [7:0] fill;
    } step_t;

    // ==================
    // Command table
    // ==================
    //   kind    side  addr   count  B     C     V     shift rnd   fill
    step_t steps [NSTEPS] = '{
        '{K_LOAD, 1'b0, 8'd0, 8'd1,  4'd0, 4'd0, 4'd0, 4'd0, 1'b1, 8'h00},
        '{K_LOAD, 1'b1, 8'd0, 8'd1,  4'd0, 4'd0, 4'd0, 4'd0, 1'b1, 8'h00},
        '{K_TILE, 1'b0, 8'd0, 8'd0,  4'd1, 4'd1, 4'd1, 4'd0, 1'b0, 8'h00},  // Single dot product
        '{K_LOAD, 1'b0, 8'd0, 8'd12, 4'd0, 4'd0, 4'd0, 4'd0, 1'b1, 8'h00},
        '{K_LOAD, 1'b1, 8'd0, 8'd8,  4'd0, 4'd0, 4'd0, 4'd0, 1'b1, 8'h00},
        '{K_TILE, 1'b0, 8'd0, 8'd0,  4'd3, 4'd2, 4'd4, 4'd3, 1'b0, 8'h00},
        '{K_NOP,  1'b0, 8'd0, 8'd0,  4'd0, 4'd0, 4'd0, 4'd0, 1'b0, 8'h00},
        '{K_BAD,  1'b0, 8'd0, 8'd0,  4'd0, 4'd0, 4'd0, 4'd0, 1'b0, 8'h00},
        '{K_LOAD, 1'b0, 8'd0, 8'd2,  4'd0, 4'd0, 4'd0, 4'd0, 1'b0, 8'h7f},  // Max positive
        '{K_LOAD, 1'b1, 8'd0, 8'd4,  4'd0, 4'd0, 4'd0, 4'd0, 1'b0, 8'h7f},
        '{K_LOAD, 1'b1, 8'd2, 8'd2,  4'd0, 4'd0, 4'd0, 4'd0, 1'b0, 8'h80},  // Overwrites column 1
        '{K_TILE, 1'b0, 8'd0, 8'd0,  4'd1, 4'd2, 4'd2, 4'd0, 1'b0, 8'h00},  // Both rails
        '{K_TILE, 1'b0, 8'd0, 8'd0,  4'd1, 4'd2, 4'd2, 4'd5, 1'b0, 8'h00},
        '{K_RAND, 1'b0, 8'd0, 8'd0,  4'd0, 4'd0, 4'd0, 4'd0, 1'b0, 8'h00},
        '{K_LOAD, 1'b0, 8'd0, 8'd12, 4'd0, 4'd0, 4'd0, 4'd0, 1'b1, 8'h00},
        '{K_LOAD, 1'b1, 8'd0, 8'd15, 4'd0, 4'd0, 4'd0, 4'd0, 1'b1, 8'h00},
        '{K_TILE, 1'b0, 8'd0, 8'd0,  4'd4, 4'd5, 4'd3, 4'd2, 1'b0, 8'h00},  // More than RES_DEPTH
        '{K_NOP,  1'b0, 8'd0, 8'd0,  4'd0, 4'd0, 4'd0, 4'd0, 1'b0, 8'h00},
        '{K_LOAD, 1'b0, 8'd1, 8'd1,  4'd0, 4'd0, 4'd0, 4'd0, 1'b1, 8'h00},
        '{K_TILE, 1'b0, 8'd0, 8'd0,  4'd2, 4'd2, 4'd1, 4'd1, 1'b0, 8'h00},
        '{K_BAD,  1'b0, 8'd0, 8'd0,  4'd0, 4'd0, 4'd0, 4'd0, 1'b0, 8'h00}
    };

    logic             i_clk;
    logic             i_rst_n;
    cmd_word_t        i_cmd;
    logic             i_cmd_valid;
    logic             o_cmd_ready;
    res_word_t        o_res;
    logic             o_res_valid;
    logic             i_res_ready;
    logic             o_busy;

    logic [CMD_W-1:0] shadow [2][TDEPTH];     // Expected tile contents
    res_word_t        exp_q [$];              // Results still owed, in order
    logic [15:0]      data_lfsr   = 16'd17360;
    logic [15:0]      rdy_lfsr    = 16'd17360;
    logic             rand_ready  = 1'b0;
    int               cycle_cnt   = 0;
    int               cycle_limit = 0;
    int               res_seen    = 0;

    engine_top #(.TILE_DEPTH(TDEPTH), .CMD_DEPTH(16), .RES_DEPTH(16)) dut0 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd       (i_cmd),
        .i_cmd_valid (i_cmd_valid),
        .o_cmd_ready (o_cmd_ready),
        .o_res       (o_res),
        .o_res_valid (o_res_valid),
        .i_res_ready (i_res_ready),
        .o_busy      (o_busy)
    );

    initial begin : clock_gen
        i_clk = 1'b0;
        forever begin
            #20 i_clk = ~i_clk;
        end
    end

    // Fibonacci, taps 16 14 13 11, output bit is the MSB
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [CMD_W-1:0] random_word();
        logic [CMD_W-1:0] w;
        w = '0;
        for (int i = 0; i < CMD_W; i++) begin
            w         = {w[CMD_W-2:0], data_lfsr[15]};  // One step per bit
            data_lfsr = lfsr_step(data_lfsr);
        end
        return w;
    endfunction

    // Reference dot product, element e sits in byte e
    function automatic res_word_t expected_result(input int b, input int c, input int v,
                                                  input int sh);
        int sum;
        int lv;
        int rv;
        sum = 0;
        for (int w = 0; w < v; w++) begin
            for (int e = 0; e < ELEMS_PER_WORD; e++) begin
                lv  = $signed(shadow[0][b * v + w][8 * e +: 8]);
                rv  = $signed(shadow[1][c * v + w][8 * e +: 8]);
                sum = sum + lv * rv;
            end
        end
        sum = sum >>> sh;  // Arithmetic, rounds toward minus infinity
        if (sum > 32767) begin
            sum = 32767;
        end else if (sum < -32768) begin
            sum = -32768;
        end
        return res_word_t'(sum);
    endfunction

    // ==================
    // Checks
    // ==================
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_res(input res_word_t act, input res_word_t exp, input string what);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED at time %0t: %s got %0d, expected %0d",
                               $time, what, act, exp));
        end
    endtask

    task automatic check_busy(input logic act, input logic exp, input string what);
        if (act !== exp) begin
            stop_run($sformatf("CHECK FAILED at time %0t: %s is %b, expected %b",
                               $time, what, act, exp));
        end
    endtask

    // Holds the word until ready was seen high at an edge
    task automatic send_word(input cmd_word_t w);
        logic rdy;
        i_cmd       = w;
        i_cmd_valid = 1'b1;
        rdy         = 1'b0;
        while (!rdy) begin
            @(negedge i_clk);
            rdy = o_cmd_ready;
            @(posedge i_clk);
            #2;
        end
        i_cmd_valid = 1'b0;
    endtask

    task automatic apply_step(input step_t s);
        cmd_word_t w;
        w = '0;
        case (s.kind)
            K_LOAD: begin
                w.load_hdr.opcode = OP_LOAD;
                w.load_hdr.side   = s.side;
                w.load_hdr.count  = s.count;
                w.load_hdr.addr   = s.addr;
                send_word(w);
                for (int i = 0; i < int'(s.count); i++) begin
                    if (s.rnd) begin
                        w = random_word();
                    end else begin
                        w = {ELEMS_PER_WORD{s.fill}};
                    end
                    shadow[s.side][(int'(s.addr) + i) % TDEPTH] = w;
                    send_word(w);
                end
            end
            K_TILE: begin
                for (int b = 0; b < int'(s.dim_b); b++) begin
                    for (int c = 0; c < int'(s.dim_c); c++) begin
                        exp_q.push_back(expected_result(b, c, int'(s.dim_v), int'(s.shift)));
                    end
                end
                w.tile_hdr.opcode = OP_TILE;
                w.tile_hdr.dim_b  = s.dim_b;
                w.tile_hdr.dim_c  = s.dim_c;
                w.tile_hdr.dim_v  = s.dim_v;
                w.tile_hdr.shift  = s.shift;
                send_word(w);
                check_busy(o_busy, 1'b1, "o_busy with a TILE queued");
            end
            K_NOP:   send_word(32'h0f0f_0f0f);  // Opcode 0, junk in the other fields
            K_BAD:   send_word(32'hb5a5_a5a5);
            default: rand_ready = 1'b1;
        endcase
    endtask

    // Host side of the result FIFO
    initial begin : result_sink
        logic next_rdy;
        i_res_ready = 1'b0;
        next_rdy    = 1'b1;
        wait (i_rst_n === 1'b0);
        @(posedge i_rst_n);
        forever begin
            @(posedge i_clk);
            #2;
            i_res_ready = next_rdy;
            @(negedge i_clk);
            if (o_res_valid && i_res_ready) begin
                if (exp_q.size() == 0) begin
                    stop_run("A result word arrived while no result was pending");
                end else begin
                    check_res(o_res, exp_q.pop_front(), $sformatf("result %0d", res_seen));
                    res_seen++;
                end
            end
            if (rand_ready) begin
                next_rdy = rdy_lfsr[15];
                rdy_lfsr = lfsr_step(rdy_lfsr);
            end else begin
                next_rdy = 1'b1;
            end
        end
    end

    initial begin : watchdog
        forever begin
            @(posedge i_clk);
            cycle_cnt++;
            if (cycle_cnt > cycle_limit) begin
                stop_run($sformatf("Timeout: the run did not finish within %0d cycles",
                                   cycle_limit));
            end
        end
    end

    // ==================
    // Main sequence
    // ==================
    initial begin : main_seq
        int n_words;
        int n_res;
        i_rst_n     = 1'b1;
        i_cmd       = '0;
        i_cmd_valid = 1'b0;
        n_words     = 0;
        n_res       = 0;
        for (int s = 0; s < 2; s++) begin
            for (int a = 0; a < TDEPTH; a++) begin
                shadow[s][a] = '0;
            end
        end
        for (int k = 0; k < NSTEPS; k++) begin
            case (steps[k].kind)
                K_LOAD: n_words += 1 + int'(steps[k].count);
                K_TILE: begin
                    n_words += 1;
                    n_res   += int'(steps[k].dim_b) * int'(steps[k].dim_c);
                end
                K_RAND:  ;
                default: n_words += 1;
            endcase
        end
        cycle_limit = 300 + 20 * n_words + 40 * n_res;

        #5 i_rst_n = 1'b0;  // Clean falling edge for the async reset
        repeat (5) @(posedge i_clk);
        #2 i_rst_n = 1'b1;

        for (int k = 0; k < NSTEPS; k++) begin
            apply_step(steps[k]);
        end

        while (exp_q.size() != 0) begin
            @(negedge i_clk);
        end
        while (o_busy) begin
            @(negedge i_clk);
        end
        repeat (4) @(negedge i_clk);  // Room for any stray result
        check_busy(o_busy, 1'b0, "o_busy after drain");
        check_busy(o_res_valid, 1'b0, "o_res_valid after drain");
        $display("TESTS PASSED");
        $finish;
    end

endmodule : tb_engine_top

/* project.f */
src/gemm_pkg.sv
src/sync_fifo.sv
src/master_control.sv
src/tile_buffer.sv
src/compute_engine.sv
src/engine_top.sv
testbench/engine_sva.sv
testbench/tb_engine_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the engine testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_engine_top \
    --Mdir obj_dir -o tb_engine_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_engine_top 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" <<< "$output"; then
    exit 0
fi
exit 1
